/* include/tag_cmp_consts.svh */
// Tag compare constants

`ifndef TAG_CMP_CONSTS_SVH
`define TAG_CMP_CONSTS_SVH

// requesters and cache geometry
`define NR_PORTS     2
`define NR_WAYS      2
`define INDEX_W      4

// tag entry is the valid bit plus the tag
`define TAG_W        7
`define DATA_W       32

// SECDED code widths for 8 and 32 data bits
`define TAG_CODE_W   13
`define DATA_CODE_W  39

// error counters and APB
`define CNT_W        16
`define APB_ADDR_W   4
`define APB_DATA_W   32

// counter registers, word aligned
`define REG_TAG_CE   4'h0
`define REG_TAG_UE   4'h4
`define REG_DATA_CE  4'h8
`define REG_DATA_UE  4'hC

`endif

/* rtl/data_check.sv */
// Data word check

`default_nettype none

`include "tag_cmp_consts.svh"

module data_check
  import tag_cmp_pkg::*;
(
  input  sram_line_t [`NR_WAYS-1:0]               sram_rdata_i,
  output logic       [`NR_WAYS-1:0][`DATA_W-1:0]  data_o,
  output ecc_flags_t                              data_flags_o
);

  logic [`NR_WAYS-1:0] ce;
  logic [`NR_WAYS-1:0] ue;

  // one decoder per way, all ways are checked on every response
  for (genvar w = 0; w < `NR_WAYS; w++) begin : g_way
    secded_dec #(
      .WIDTH (`DATA_W)
    ) data_dec_inst (
      .code_i (sram_rdata_i[w].data),
      .data_o (data_o[w]),
      .ce_o   (ce[w]),
      .ue_o   (ue[w])
    );
  end

  assign data_flags_o = '{ce: ce, ue: ue};

endmodule

`default_nettype wire

/* rtl/err_counter_apb.sv */
// ECC error counters on APB

`default_nettype none

`include "tag_cmp_consts.svh"

module err_counter_apb
  import tag_cmp_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  ecc_flags_t              tag_flags_i,
  input  ecc_flags_t              data_flags_i,
  input  logic [`NR_WAYS-1:0]     rd_ways_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [`APB_ADDR_W-1:0]  paddr_i,
  input  logic [`APB_DATA_W-1:0]  pwdata_i,
  output logic [`APB_DATA_W-1:0]  prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o
);

  localparam int unsigned NR_CNT = 4;

  logic [NR_CNT-1:0][`CNT_W-1:0] cnt_q;
  logic [NR_CNT-1:0]             evt;
  logic [NR_CNT-1:0]             clr;
  logic [1:0]                    reg_idx;
  logic                          reg_hit;
  logic                          access;

  // ----------------------------------------------------------------------
  // error events count only for ways that were actually read
  // ----------------------------------------------------------------------
  assign evt[0] = |(tag_flags_i.ce & rd_ways_i);
  assign evt[1] = |(tag_flags_i.ue & rd_ways_i);
  assign evt[2] = |(data_flags_i.ce & rd_ways_i);
  assign evt[3] = |(data_flags_i.ue & rd_ways_i);

  // ----------------------------------------------------------------------
  // APB decode without wait states
  // ----------------------------------------------------------------------
  always_comb begin
    reg_hit = 1'b1;
    reg_idx = 2'd0;
    case (paddr_i)
      `REG_TAG_CE:  reg_idx = 2'd0;
      `REG_TAG_UE:  reg_idx = 2'd1;
      `REG_DATA_CE: reg_idx = 2'd2;
      `REG_DATA_UE: reg_idx = 2'd3;
      default:      reg_hit = 1'b0;
    endcase
  end

  assign access    = psel_i & penable_i;
  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~reg_hit;
  assign prdata_o  = reg_hit ? `APB_DATA_W'(cnt_q[reg_idx]) : '0;

  // any write clears the addressed counter
  always_comb begin
    clr = '0;
    if (access && pwrite_i && reg_hit) begin
      clr[reg_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int k = 0; k < NR_CNT; k++) begin
        if (clr[k]) begin
          cnt_q[k] <= '0;
        end else if (evt[k] && (cnt_q[k] != '1)) begin
          cnt_q[k] <= cnt_q[k] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/port_arbiter.sv */
// Port arbiter with read-modify-write

`default_nettype none

`include "tag_cmp_consts.svh"

module port_arbiter
  import tag_cmp_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  port_req_t [`NR_PORTS-1:0]   req_i,
  input  line_t     [`NR_WAYS-1:0]    corr_lines_i,
  output logic      [`NR_PORTS-1:0]   gnt_o,
  output sram_req_t                   sram_req_o,
  output logic      [`NR_WAYS-1:0]    rd_ways_o,
  output logic      [`NR_PORTS-1:0]   sel_id_o
);

  localparam int unsigned NR_BYTES = `DATA_W / 8;

  store_state_e            state_d, state_q;
  port_req_t               buf_d, buf_q;
  logic [`NR_PORTS-1:0]    id_d, id_q;
  logic [`NR_WAYS-1:0]     rd_ways_q;
  sram_req_t               req_ctl;
  line_t                   wline;
  line_t                   old_line;
  logic [`DATA_W-1:0]      merged_data;
  logic [`TAG_CODE_W-1:0]  tag_code;
  logic [`DATA_CODE_W-1:0] data_code;

  // some bytes enabled, but not all
  function automatic logic is_partial(input port_req_t r);
    return r.we && (r.be.data != '0) && (r.be.data != '1);
  endfunction

  // ----------------------------------------------------------------------
  // merge path for the second cycle of a partial write
  // ----------------------------------------------------------------------
  // lowest selected way supplies the old word
  always_comb begin
    old_line = '0;
    for (int w = `NR_WAYS - 1; w >= 0; w--) begin
      if (buf_q.ways[w]) begin
        old_line = corr_lines_i[w];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < NR_BYTES; b++) begin
      merged_data[8*b +: 8] = buf_q.be.data[b] ? buf_q.wline.data[8*b +: 8]
                                               : old_line.data[8*b +: 8];
    end
  end

  // ----------------------------------------------------------------------
  // priority select and request issue
  // ----------------------------------------------------------------------
  always_comb begin
    logic found;
    found   = 1'b0;
    state_d = NORMAL;
    buf_d   = buf_q;
    id_d    = id_q;
    gnt_o   = '0;
    wline   = '0;
    req_ctl = '0;
    if (state_q == NORMAL) begin
      for (int i = 0; i < `NR_PORTS; i++) begin
        if (!found && (req_i[i].ways != '0)) begin
          found         = 1'b1;
          id_d          = '0;
          id_d[i]       = 1'b1;
          req_ctl.ways  = req_i[i].ways;
          req_ctl.index = req_i[i].index;
          wline         = req_i[i].wline;
          if (is_partial(req_i[i])) begin
            // read the old word first, grant comes next cycle
            state_d = LOAD_AND_STORE;
            buf_d   = req_i[i];
          end else begin
            gnt_o[i]        = 1'b1;
            req_ctl.we      = req_i[i].we;
            req_ctl.tag_we  = req_i[i].we & req_i[i].be.tag;
            req_ctl.data_we = req_i[i].we & (|req_i[i].be.data);
          end
        end
      end
    end else begin
      gnt_o           = id_q;
      req_ctl.ways    = buf_q.ways;
      req_ctl.index   = buf_q.index;
      req_ctl.we      = 1'b1;
      req_ctl.tag_we  = buf_q.be.tag;
      req_ctl.data_we = 1'b1;
      wline           = buf_q.wline;
      wline.data      = merged_data;
    end
  end

  secded_enc #(
    .WIDTH (`TAG_W + 1)
  ) tag_enc_inst (
    .data_i ({wline.valid, wline.tag}),
    .code_o (tag_code)
  );

  secded_enc #(
    .WIDTH (`DATA_W)
  ) data_enc_inst (
    .data_i (wline.data),
    .code_o (data_code)
  );

  always_comb begin
    sram_req_o            = req_ctl;
    sram_req_o.wline.tag  = tag_code;
    sram_req_o.wline.data = data_code;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= NORMAL;
      id_q      <= '0;
      rd_ways_q <= '0;
    end else begin
      state_q   <= state_d;
      id_q      <= id_d;
      rd_ways_q <= req_ctl.we ? '0 : req_ctl.ways;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
  end

  assign rd_ways_o = rd_ways_q;
  assign sel_id_o  = id_q;

endmodule

`default_nettype wire

/* rtl/secded_dec.sv */
// SECDED decoder

`default_nettype none

module secded_dec
  import tag_cmp_pkg::*;
#(
  parameter  int unsigned WIDTH  = 8,
  localparam int unsigned PAR_W  = secded_par_w(WIDTH),
  localparam int unsigned CODE_W = WIDTH + PAR_W + 1
) (
  input  logic [CODE_W-1:0] code_i,
  output logic [WIDTH-1:0]  data_o,
  output logic              ce_o,
  output logic              ue_o
);

  logic [PAR_W-1:0]  syndrome;
  logic              overall;
  logic [CODE_W-1:0] fixed;

  // syndrome is the xor of the positions of all set bits
  always_comb begin
    syndrome = '0;
    for (int unsigned i = 1; i < CODE_W; i++) begin
      if (code_i[i]) begin
        syndrome = syndrome ^ PAR_W'(i);
      end
    end
  end

  assign overall = ^code_i;

  // single error, flip the pointed bit (syndrome 0 is the parity bit itself)
  always_comb begin
    fixed = code_i;
    for (int unsigned i = 0; i < CODE_W; i++) begin
      if (overall && (syndrome == i)) begin
        fixed[i] = ~code_i[i];
      end
    end
  end

  always_comb begin
    int unsigned d;
    data_o = '0;
    d = 0;
    for (int unsigned i = 1; i < CODE_W; i++) begin
      if ((i & (i - 1)) != 0) begin
        data_o[d] = fixed[i];
        d++;
      end
    end
  end

  assign ce_o = overall;
  // even overall parity with a nonzero syndrome means two flipped bits
  assign ue_o = ~overall & (syndrome != '0);

endmodule

`default_nettype wire

/* rtl/secded_enc.sv */
// SECDED encoder

`default_nettype none

module secded_enc
  import tag_cmp_pkg::*;
#(
  parameter  int unsigned WIDTH  = 8,
  localparam int unsigned PAR_W  = secded_par_w(WIDTH),
  localparam int unsigned CODE_W = WIDTH + PAR_W + 1
) (
  input  logic [WIDTH-1:0]  data_i,
  output logic [CODE_W-1:0] code_o
);

  // bit 0 holds overall parity, bits 1.. are Hamming positions
  always_comb begin
    int unsigned d;
    code_o = '0;
    d = 0;
    // data fills every position that is not a power of two
    for (int unsigned i = 1; i < CODE_W; i++) begin
      if ((i & (i - 1)) != 0) begin
        code_o[i] = data_i[d];
        d++;
      end
    end
    // parity bit 2^k covers all positions with bit k set
    for (int unsigned k = 0; k < PAR_W; k++) begin
      for (int unsigned i = 1; i < CODE_W; i++) begin
        if ((((i >> k) & 1) != 0) && (i != (1 << k))) begin
          code_o[1 << k] = code_o[1 << k] ^ code_o[i];
        end
      end
    end
    code_o[0] = ^code_o;
  end

endmodule

`default_nettype wire

/* rtl/tag_check.sv */
// Tag check and hit detection

`default_nettype none

`include "tag_cmp_consts.svh"

module tag_check
  import tag_cmp_pkg::*;
(
  input  sram_line_t [`NR_WAYS-1:0]              sram_rdata_i,
  input  logic       [`NR_PORTS-1:0][`TAG_W-1:0] tag_i,
  input  logic       [`NR_PORTS-1:0]             sel_id_i,
  output logic       [`NR_WAYS-1:0][`TAG_W:0]    tag_o,
  output logic       [`NR_WAYS-1:0]              hit_way_o,
  output ecc_flags_t                             tag_flags_o
);

  logic [`TAG_W-1:0]   sel_tag;
  logic [`NR_WAYS-1:0] ce;
  logic [`NR_WAYS-1:0] ue;

  // late tag of the port that read last cycle
  always_comb begin
    sel_tag = '0;
    for (int i = 0; i < `NR_PORTS; i++) begin
      if (sel_id_i[i]) begin
        sel_tag = sel_tag | tag_i[i];
      end
    end
  end

  for (genvar w = 0; w < `NR_WAYS; w++) begin : g_way
    secded_dec #(
      .WIDTH (`TAG_W + 1)
    ) tag_dec_inst (
      .code_i (sram_rdata_i[w].tag),
      .data_o (tag_o[w]),
      .ce_o   (ce[w]),
      .ue_o   (ue[w])
    );

    // msb of the corrected entry is the valid bit
    assign hit_way_o[w] = tag_o[w][`TAG_W] && (tag_o[w][`TAG_W-1:0] == sel_tag);
  end

  assign tag_flags_o = '{ce: ce, ue: ue};

endmodule

`default_nettype wire

/* rtl/tag_cmp_pkg.sv */
// Tag compare types

`default_nettype none

`include "tag_cmp_consts.svh"

package tag_cmp_pkg;

  // ----------------------------------------------------------------------
  // plain request side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                valid;
    logic [`TAG_W-1:0]   tag;
    logic [`DATA_W-1:0]  data;
  } line_t;

  // one enable for the whole tag entry, one per data byte
  typedef struct packed {
    logic                  tag;
    logic [`DATA_W/8-1:0]  data;
  } be_t;

  typedef struct packed {
    logic [`NR_WAYS-1:0]  ways;
    logic                 we;
    logic [`INDEX_W-1:0]  index;
    line_t                wline;
    be_t                  be;
  } port_req_t;

  // ----------------------------------------------------------------------
  // encoded SRAM side
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [`TAG_CODE_W-1:0]   tag;
    logic [`DATA_CODE_W-1:0]  data;
  } sram_line_t;

  typedef struct packed {
    logic [`NR_WAYS-1:0]  ways;
    logic                 we;
    logic [`INDEX_W-1:0]  index;
    logic                 tag_we;
    logic                 data_we;
    sram_line_t           wline;
  } sram_req_t;

  typedef struct packed {
    logic [`NR_WAYS-1:0]  ce;
    logic [`NR_WAYS-1:0]  ue;
  } ecc_flags_t;

  typedef enum logic {
    NORMAL,
    LOAD_AND_STORE
  } store_state_e;

  // number of Hamming parity bits for a data width
  function automatic int unsigned secded_par_w(input int unsigned width);
    int unsigned p;
    p = 1;
    while ((1 << p) < width + p + 1) begin
      p++;
    end
    return p;
  endfunction

endpackage

`default_nettype wire

/* rtl/tag_cmp_top.sv */
// Tag compare front end

`default_nettype none

`include "tag_cmp_consts.svh"

module tag_cmp_top
  import tag_cmp_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // requester ports
  input  port_req_t  [`NR_PORTS-1:0]             req_i,
  input  logic       [`NR_PORTS-1:0][`TAG_W-1:0] tag_i,
  output logic       [`NR_PORTS-1:0]             gnt_o,
  output line_t      [`NR_WAYS-1:0]              rdata_o,
  output logic       [`NR_WAYS-1:0]              hit_way_o,
  // SRAM
  output sram_req_t                              sram_req_o,
  input  sram_line_t [`NR_WAYS-1:0]              sram_rdata_i,
  // APB
  input  logic                                   psel_i,
  input  logic                                   penable_i,
  input  logic                                   pwrite_i,
  input  logic       [`APB_ADDR_W-1:0]           paddr_i,
  input  logic       [`APB_DATA_W-1:0]           pwdata_i,
  output logic       [`APB_DATA_W-1:0]           prdata_o,
  output logic                                   pready_o,
  output logic                                   pslverr_o
);

  logic       [`NR_WAYS-1:0]              rd_ways;
  logic       [`NR_PORTS-1:0]             sel_id;
  line_t      [`NR_WAYS-1:0]              corr_lines;
  logic       [`NR_WAYS-1:0][`TAG_W:0]    tag_entries;
  logic       [`NR_WAYS-1:0][`DATA_W-1:0] data_words;
  ecc_flags_t                             tag_flags;
  ecc_flags_t                             data_flags;

  port_arbiter port_arbiter_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .corr_lines_i (corr_lines),
    .gnt_o        (gnt_o),
    .sram_req_o   (sram_req_o),
    .rd_ways_o    (rd_ways),
    .sel_id_o     (sel_id)
  );

  tag_check tag_check_inst (
    .sram_rdata_i (sram_rdata_i),
    .tag_i        (tag_i),
    .sel_id_i     (sel_id),
    .tag_o        (tag_entries),
    .hit_way_o    (hit_way_o),
    .tag_flags_o  (tag_flags)
  );

  data_check data_check_inst (
    .sram_rdata_i (sram_rdata_i),
    .data_o       (data_words),
    .data_flags_o (data_flags)
  );

  // corrected lines go out and back to the merge path
  for (genvar w = 0; w < `NR_WAYS; w++) begin : g_line
    assign corr_lines[w] = '{valid: tag_entries[w][`TAG_W],
                             tag:   tag_entries[w][`TAG_W-1:0],
                             data:  data_words[w]};
  end

  assign rdata_o = corr_lines;

  err_counter_apb err_counter_apb_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tag_flags_i  (tag_flags),
    .data_flags_i (data_flags),
    .rd_ways_i    (rd_ways),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o)
  );

endmodule

`default_nettype wire

/* verification/tag_cmp_sva.sv */
// Grant and hit assertions

`default_nettype none

`include "tag_cmp_consts.svh"

module tag_cmp_sva
  import tag_cmp_pkg::*;
(
  input logic                           clk_i,
  input logic                           rst_ni,
  input port_req_t [`NR_PORTS-1:0]      req_i,
  input logic      [`NR_PORTS-1:0]      gnt_o,
  input logic      [`NR_WAYS-1:0]       rd_ways,
  input logic      [`NR_WAYS-1:0]       hit_way_o
);

  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;

  // port i is the lowest requester and asks for a byte-partial write
  function automatic logic wins_partial(input port_req_t [`NR_PORTS-1:0] r, input int i);
    logic busy;
    busy = 1'b0;
    for (int j = 0; j < i; j++) begin
      busy = busy | (r[j].ways != '0);
    end
    return !busy && (r[i].ways != '0) && r[i].we &&
           (r[i].be.data != '0) && (r[i].be.data != '1);
  endfunction

  a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o))
    else begin
      fail_cnt++;
      $error("more than one port granted in a cycle");
    end

  // rd_ways is registered, so it marks the response cycle
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rd_ways != '0) |-> $onehot0(hit_way_o))
    else begin
      fail_cnt++;
      $error("hit vector has more than one way set");
    end

  for (genvar i = 0; i < `NR_PORTS; i++) begin : g_port
    a_partial_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ((gnt_o == '0) && wins_partial(req_i, i)) |=> gnt_o[i])
      else begin
        fail_cnt++;
        $error("partial write of port %0d not granted in the next cycle", i);
      end
  end

endmodule

bind tag_cmp_top tag_cmp_sva tag_cmp_sva_inst (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (req_i),
  .gnt_o     (gnt_o),
  .rd_ways   (rd_ways),
  .hit_way_o (hit_way_o)
);

`default_nettype wire

/* verification/tag_cmp_tb.sv */
// Tag compare testbench

`default_nettype none

`include "tag_cmp_consts.svh"

module tag_cmp_tb
  import tag_cmp_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned CLK_PERIOD   = 10;
  localparam int unsigned NR_TESTS     = 6;
  localparam int unsigned CYCLE_BUDGET = 400;
  localparam be_t         BE_FULL      = '{tag: 1'b1, data: '1};

  logic                                   clk_i;
  logic                                   rst_ni;
  port_req_t  [`NR_PORTS-1:0]             req_i;
  logic       [`NR_PORTS-1:0][`TAG_W-1:0] tag_i;
  logic       [`NR_PORTS-1:0]             gnt_o;
  line_t      [`NR_WAYS-1:0]              rdata_o;
  logic       [`NR_WAYS-1:0]              hit_way_o;
  sram_req_t                              sram_req_o;
  sram_line_t [`NR_WAYS-1:0]              sram_rdata_i = '0;
  logic                                   psel_i;
  logic                                   penable_i;
  logic                                   pwrite_i;
  logic       [`APB_ADDR_W-1:0]           paddr_i;
  logic       [`APB_DATA_W-1:0]           pwdata_i;
  logic       [`APB_DATA_W-1:0]           prdata_o;
  logic                                   pready_o;
  logic                                   pslverr_o;

  integer             seed;
  logic [`TAG_W-1:0]  tag_a;
  logic [`TAG_W-1:0]  tag_b;
  logic [`DATA_W-1:0] data_a;
  logic [`DATA_W-1:0] data_b;
  logic [`DATA_W-1:0] merged_exp;

  // ----------------------------------------------------------------------
  // SRAM model with one cycle read latency
  // ----------------------------------------------------------------------
  logic [`TAG_CODE_W-1:0]  mem_tag  [`NR_WAYS][1 << `INDEX_W];
  logic [`DATA_CODE_W-1:0] mem_data [`NR_WAYS][1 << `INDEX_W];
  logic                    flip_en = 1'b0;
  int                      flip_way;
  int                      flip_idx;
  logic [`TAG_CODE_W-1:0]  flip_tag;
  logic [`DATA_CODE_W-1:0] flip_data;

  always @(posedge clk_i) begin
    for (int w = 0; w < `NR_WAYS; w++) begin
      if (sram_req_o.ways[w]) begin
        if (!sram_req_o.we) begin
          sram_rdata_i[w].tag  <= mem_tag[w][sram_req_o.index];
          sram_rdata_i[w].data <= mem_data[w][sram_req_o.index];
        end
        if (sram_req_o.we && sram_req_o.tag_we) begin
          mem_tag[w][sram_req_o.index] <= sram_req_o.wline.tag;
        end
        if (sram_req_o.we && sram_req_o.data_we) begin
          mem_data[w][sram_req_o.index] <= sram_req_o.wline.data;
        end
      end
    end
    // injected errors land on the stored codes
    if (flip_en) begin
      mem_tag[flip_way][flip_idx]  <= mem_tag[flip_way][flip_idx] ^ flip_tag;
      mem_data[flip_way][flip_idx] <= mem_data[flip_way][flip_idx] ^ flip_data;
    end
  end

  initial begin
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  initial begin
    #(NR_TESTS * CYCLE_BUDGET * CLK_PERIOD);
    $display("Error: the run timed out before all tests finished");
    $display(">>> FAIL");
    $fatal(1);
  end

  tag_cmp_top tag_cmp_top_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .tag_i        (tag_i),
    .gnt_o        (gnt_o),
    .rdata_o      (rdata_o),
    .hit_way_o    (hit_way_o),
    .sram_req_o   (sram_req_o),
    .sram_rdata_i (sram_rdata_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o)
  );

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (act_v !== exp_v) begin
      $display("Fail %s expected %h actual %h", name, exp_v, act_v);
      $display(">>> FAIL");
      $fatal(1);
    end
  endtask

  function automatic port_req_t make_req(input logic [`NR_WAYS-1:0] ways, input logic we,
                                         input logic [`INDEX_W-1:0] index,
                                         input line_t wline, input be_t be);
    return '{ways: ways, we: we, index: index, wline: wline, be: be};
  endfunction

  task automatic wait_gnt(input int p);
    do begin
      @(negedge clk_i);
    end while (!gnt_o[p]);
  endtask

  task automatic end_req(input int p);
    @(posedge clk_i);
    req_i[p] <= '0;
  endtask

  task automatic write_line(input int p, input logic [`NR_WAYS-1:0] ways,
                            input logic [`INDEX_W-1:0] index, input line_t wline,
                            input be_t be);
    @(posedge clk_i);
    req_i[p] <= make_req(ways, 1'b1, index, wline, be);
    wait_gnt(p);
    end_req(p);
  endtask

  task automatic read_line(input int p, input logic [`NR_WAYS-1:0] ways,
                           input logic [`INDEX_W-1:0] index, input logic [`TAG_W-1:0] tag,
                           output logic [`NR_WAYS-1:0] hit,
                           output line_t [`NR_WAYS-1:0] lines);
    @(posedge clk_i);
    req_i[p] <= make_req(ways, 1'b0, index, '0, '0);
    tag_i[p] <= tag;
    wait_gnt(p);
    end_req(p);
    @(negedge clk_i);
    hit   = hit_way_o;
    lines = rdata_o;
  endtask

  task automatic flip_bits(input int way, input int index,
                           input logic [`TAG_CODE_W-1:0] tag_mask,
                           input logic [`DATA_CODE_W-1:0] data_mask);
    @(posedge clk_i);
    flip_en   <= 1'b1;
    flip_way  <= way;
    flip_idx  <= index;
    flip_tag  <= tag_mask;
    flip_data <= data_mask;
    @(posedge clk_i);
    flip_en <= 1'b0;
  endtask

  task automatic apb_read(input logic [`APB_ADDR_W-1:0] addr,
                          output logic [`APB_DATA_W-1:0] data, output logic err);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b0;
    paddr_i   <= addr;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    check_value("pready_o", 1'b1, pready_o);
    data = prdata_o;
    err  = pslverr_o;
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic apb_write(input logic [`APB_ADDR_W-1:0] addr,
                           input logic [`APB_DATA_W-1:0] data);
    @(posedge clk_i);
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= 1'b1;
    paddr_i   <= addr;
    pwdata_i  <= data;
    @(posedge clk_i);
    penable_i <= 1'b1;
    @(negedge clk_i);
    check_value("pslverr_o", 1'b0, pslverr_o);
    @(posedge clk_i);
    psel_i    <= 1'b0;
    penable_i <= 1'b0;
  endtask

  task automatic check_counter(input string name, input logic [`APB_ADDR_W-1:0] addr,
                               input int unsigned exp_cnt);
    logic [`APB_DATA_W-1:0] data;
    logic                   err;
    apb_read(addr, data, err);
    check_value("pslverr_o", 1'b0, err);
    check_value(name, exp_cnt, data);
  endtask

  // every entry gets an invalid line whose data depends on way and index
  task automatic fill_memory();
    line_t wline;
    for (int w = 0; w < `NR_WAYS; w++) begin
      for (int i = 0; i < (1 << `INDEX_W); i++) begin
        wline = '{valid: 1'b0, tag: `TAG_W'(i), data: {4'(w), 4'(i), 24'h3ca55a}};
        write_line(0, `NR_WAYS'(1 << w), `INDEX_W'(i), wline, BE_FULL);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------
  task automatic test_hit_and_miss();
    logic [`NR_WAYS-1:0]  hit;
    line_t [`NR_WAYS-1:0] lines;
    tag_a  = $random(seed);
    data_a = $random(seed);
    write_line(0, 2'b01, 4'd3, '{valid: 1'b1, tag: tag_a, data: data_a}, BE_FULL);
    read_line(0, 2'b11, 4'd3, tag_a, hit, lines);
    check_value("hit_way_o", 2'b01, hit);
    check_value("rdata_o[0].data", data_a, lines[0].data);
    read_line(0, 2'b11, 4'd3, tag_a ^ 7'h01, hit, lines);
    check_value("hit_way_o", 2'b00, hit);
  endtask

  task automatic test_priority();
    logic [`NR_WAYS-1:0]  hit;
    line_t [`NR_WAYS-1:0] lines;
    tag_b  = $random(seed);
    data_b = $random(seed);
    @(posedge clk_i);
    req_i[0] <= make_req(2'b01, 1'b1, 4'd5, '{valid: 1'b1, tag: tag_b ^ 7'h10,
                                              data: ~data_b}, BE_FULL);
    req_i[1] <= make_req(2'b10, 1'b1, 4'd6, '{valid: 1'b1, tag: tag_b, data: data_b},
                         BE_FULL);
    @(negedge clk_i);
    check_value("gnt_o", 2'b01, gnt_o);
    end_req(0);
    @(negedge clk_i);
    check_value("gnt_o", 2'b10, gnt_o);
    end_req(1);
    // port 0 presents a different late tag, port 1 must be the one selected
    tag_i[0] <= ~tag_b;
    read_line(1, 2'b11, 4'd6, tag_b, hit, lines);
    check_value("hit_way_o", 2'b10, hit);
    check_value("rdata_o[1].data", data_b, lines[1].data);
  endtask

  task automatic test_partial_write();
    logic [`DATA_W-1:0]   new_data;
    logic [`NR_WAYS-1:0]  hit;
    line_t [`NR_WAYS-1:0] lines;
    be_t                  be;
    new_data = $random(seed);
    be       = '{tag: 1'b0, data: 4'b0101};
    for (int b = 0; b < `DATA_W / 8; b++) begin
      merged_exp[8*b +: 8] = be.data[b] ? new_data[8*b +: 8] : data_a[8*b +: 8];
    end
    @(posedge clk_i);
    req_i[0] <= make_req(2'b01, 1'b1, 4'd3, '{valid: 1'b1, tag: tag_a, data: new_data}, be);
    @(negedge clk_i);
    check_value("gnt_o", 2'b00, gnt_o);
    check_value("sram_req_o.we", 1'b0, sram_req_o.we);
    check_value("sram_req_o.ways", 2'b01, sram_req_o.ways);
    @(negedge clk_i);
    check_value("gnt_o", 2'b01, gnt_o);
    check_value("sram_req_o.we", 1'b1, sram_req_o.we);
    check_value("sram_req_o.tag_we", 1'b0, sram_req_o.tag_we);
    end_req(0);
    read_line(0, 2'b11, 4'd3, tag_a, hit, lines);
    check_value("hit_way_o", 2'b01, hit);
    check_value("rdata_o[0].data", merged_exp, lines[0].data);
  endtask

  task automatic test_single_error();
    logic [`NR_WAYS-1:0]  hit;
    line_t [`NR_WAYS-1:0] lines;
    flip_bits(0, 3, 13'h0004, 39'h200);
    read_line(0, 2'b11, 4'd3, tag_a, hit, lines);
    check_value("hit_way_o", 2'b01, hit);
    check_value("rdata_o[0].tag", tag_a, lines[0].tag);
    check_value("rdata_o[0].data", merged_exp, lines[0].data);
    check_counter("tag_ce", `REG_TAG_CE, 1);
    check_counter("data_ce", `REG_DATA_CE, 1);
    check_counter("tag_ue", `REG_TAG_UE, 0);
  endtask

  task automatic test_double_error();
    logic [`NR_WAYS-1:0]  hit;
    line_t [`NR_WAYS-1:0] lines;
    flip_bits(1, 6, '0, 39'h28);
    read_line(1, 2'b11, 4'd6, tag_b, hit, lines);
    check_value("hit_way_o", 2'b10, hit);
    check_counter("data_ue", `REG_DATA_UE, 1);
    check_counter("data_ce", `REG_DATA_CE, 1);
  endtask

  task automatic test_counter_clear();
    logic [`APB_DATA_W-1:0] data;
    logic                   err;
    apb_write(`REG_TAG_CE, $random(seed));
    apb_write(`REG_DATA_CE, $random(seed));
    apb_write(`REG_DATA_UE, $random(seed));
    check_counter("tag_ce", `REG_TAG_CE, 0);
    check_counter("data_ce", `REG_DATA_CE, 0);
    check_counter("data_ue", `REG_DATA_UE, 0);
    apb_read(4'h2, data, err);
    check_value("pslverr_o", 1'b1, err);
  endtask

  initial begin
    seed      = 32'ha5222340;
    rst_ni    = 1'b0;
    req_i     = '0;
    tag_i     = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    // idle outputs right after reset
    @(negedge clk_i);
    check_value("gnt_o", 2'b00, gnt_o);
    check_value("sram_req_o.ways", 2'b00, sram_req_o.ways);
    check_value("pslverr_o", 1'b0, pslverr_o);
    fill_memory();
    test_hit_and_miss();
    test_priority();
    test_partial_write();
    test_single_error();
    test_double_error();
    test_counter_clear();
    @(posedge clk_i);
    if (tag_cmp_top_inst.tag_cmp_sva_inst.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display("Error: %0d assertion failures were reported",
               tag_cmp_top_inst.tag_cmp_sva_inst.fail_cnt);
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
rtl/tag_cmp_pkg.sv
rtl/secded_enc.sv
rtl/secded_dec.sv
rtl/port_arbiter.sv
rtl/tag_check.sv
rtl/data_check.sv
rtl/err_counter_apb.sv
rtl/tag_cmp_top.sv
verification/tag_cmp_sva.sv
verification/tag_cmp_tb.sv
